// File: rtl/mem_stage_pkg.sv
package mem_stage_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;
    localparam int NUM_LANES = XLEN / 8;
    localparam int RAM_DEPTH = 256;              // Words
    localparam int RAM_IDX_W = $clog2(RAM_DEPTH);

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [NUM_LANES-1:0] strb_t;
    typedef logic [1:0]           acc_size_t;
    typedef logic [1:0]           lane_t;        // Byte offset in word
    typedef logic [RAM_IDX_W-1:0] ram_idx_t;

    localparam acc_size_t SIZE_BYTE = 2'd0;
    localparam acc_size_t SIZE_HALF = 2'd1;
    localparam acc_size_t SIZE_WORD = 2'd2;

    typedef struct packed {
        logic      valid;
        reg_idx_t  rd;
        word_t     alu_data;
        logic      load;
        logic      store;
        acc_size_t size;
        logic      sext;
        word_t     addr;
        word_t     store_data;
    } exec_req_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } reg_wr_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        strb_t    strb;
        logic     sext;
        lane_t    lane;
    } mem_rd_t;

    typedef struct packed {
        logic     valid;
        ram_idx_t addr;
        strb_t    strb;
        word_t    data;                          // Already lane aligned
    } mem_wr_t;

endpackage

// File: rtl/mem_cushion.sv
`timescale 1ns/10ps

module mem_cushion import mem_stage_pkg::*; (
    input  logic      CLK,
    input  logic      rst,
    input  exec_req_t req,
    output reg_wr_t   pass_w,
    output mem_rd_t   load_r,
    output mem_wr_t   store_w,
    output ram_idx_t  rd_idx,
    output logic      fault
);

    lane_t lane;
    strb_t strb;
    word_t wdata;
    logic  mem_acc;
    logic  misaligned;

    assign lane    = req.addr[1:0];
    assign mem_acc = req.valid && (req.load || req.store);

    // Strobe and alignment check from size and offset
    always_comb begin
        case (req.size)
            SIZE_BYTE: begin
                strb       = 4'b0001 << lane;
                misaligned = 1'b0;
            end
            SIZE_HALF: begin
                strb       = 4'b0011 << lane;
                misaligned = lane[0];
            end
            default: begin                       // Word
                strb       = 4'b1111;
                misaligned = |lane;
            end
        endcase
    end

    assign wdata = req.store_data << {lane, 3'b000};  // Move into byte lanes

    always_ff @(posedge CLK) begin
        pass_w.rd     <= req.rd;
        pass_w.data   <= req.alu_data;

        load_r.rd     <= req.rd;
        load_r.strb   <= strb;
        load_r.sext   <= req.sext;
        load_r.lane   <= lane;

        store_w.addr  <= req.addr[RAM_IDX_W+1:2];
        store_w.strb  <= strb;
        store_w.data  <= wdata;

        if (rst) begin
            pass_w.valid  <= 1'b0;
            load_r.valid  <= 1'b0;
            store_w.valid <= 1'b0;
            fault         <= 1'b0;
        end else begin
            pass_w.valid  <= req.valid && !req.load && !req.store && (req.rd != '0);
            load_r.valid  <= req.valid && req.load && !misaligned;
            store_w.valid <= req.valid && req.store && !misaligned;
            fault         <= mem_acc && misaligned;   // Access dropped
        end
    end

    // Loads and stores share the word index
    assign rd_idx = store_w.addr;

    a_ld_st_excl: assert property (
        @(posedge CLK) disable iff (rst)
        req.valid |-> !(req.load && req.store)
    ) else $error("load and store both set on one request");

endmodule

// File: rtl/data_ram.sv
`timescale 1ns/10ps

module data_ram import mem_stage_pkg::*; (
    input  logic     CLK,
    input  ram_idx_t rd_idx,
    output word_t    rdata,
    input  mem_wr_t  wr
);

    word_t mem [RAM_DEPTH];
    logic  hit;

    assign hit = wr.valid && (wr.addr == rd_idx);

    always_ff @(posedge CLK) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (wr.valid && wr.strb[i]) begin
                mem[wr.addr][8*i +: 8] <= wr.data[8*i +: 8];
            end

            // Write-first for the lanes written this edge
            if (hit && wr.strb[i]) begin
                rdata[8*i +: 8] <= wr.data[8*i +: 8];
            end else begin
                rdata[8*i +: 8] <= mem[rd_idx][8*i +: 8];
            end
        end
    end

    // Strobe comes from the cushion stage two edges earlier
    a_wr_strb: assert property (
        @(posedge CLK)
        wr.valid |-> (wr.strb != '0)
    ) else $error("RAM write with empty strobe");

endmodule

// File: rtl/mem_read.sv
`timescale 1ns/10ps

module mem_read import mem_stage_pkg::*; (
    input  logic    CLK,
    input  logic    rst,
    input  reg_wr_t pass_w,
    input  mem_rd_t load_r,
    input  mem_wr_t store_w,
    input  word_t   rdata,
    output reg_wr_t pass_q,
    output reg_wr_t load_q,
    output mem_wr_t store_q
);

    reg_wr_t pass_hold;
    mem_rd_t load_hold;
    mem_wr_t store_hold;
    word_t   shifted;
    word_t   ld_data;
    logic    ld_sign;

    always_ff @(posedge CLK) begin
        pass_hold  <= pass_w;
        load_hold  <= load_r;
        store_hold <= store_w;
        if (rst) begin                           // Valid bits only
            pass_hold.valid  <= 1'b0;
            load_hold.valid  <= 1'b0;
            store_hold.valid <= 1'b0;
        end
    end

    // Addressed bytes down to bit 0
    assign shifted = rdata >> {load_hold.lane, 3'b000};

    always_comb begin
        case (load_hold.strb)
            4'b1111: begin
                ld_sign = 1'b0;
                ld_data = shifted;
            end
            4'b0011, 4'b1100: begin              // Halfword
                ld_sign = load_hold.sext & shifted[15];
                ld_data = {{16{ld_sign}}, shifted[15:0]};
            end
            default: begin
                ld_sign = load_hold.sext & shifted[7];
                ld_data = {{24{ld_sign}}, shifted[7:0]};
            end
        endcase
    end

    assign load_q.valid = load_hold.valid;
    assign load_q.rd    = load_hold.rd;
    assign load_q.data  = ld_data;

    assign pass_q  = pass_hold;
    assign store_q = store_hold;

endmodule

// File: rtl/mem_write.sv
`timescale 1ns/10ps

module mem_write import mem_stage_pkg::*; (
    input  logic    CLK,
    input  logic    rst,
    input  reg_wr_t pass_q,
    input  reg_wr_t load_q,
    input  mem_wr_t store_q,
    output mem_wr_t ram_wr,
    output reg_wr_t retire
);

    logic take_load;

    // Loads to x0 still read but never retire
    assign take_load = load_q.valid && (load_q.rd != '0);

    assign ram_wr = store_q;                     // Commit store at next edge

    always_ff @(posedge CLK) begin
        if (take_load) begin
            retire.rd   <= load_q.rd;
            retire.data <= load_q.data;
        end else begin
            retire.rd   <= pass_q.rd;
            retire.data <= pass_q.data;
        end

        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= take_load || pass_q.valid;
        end
    end

    // One request per cycle upstream, so at most one writer
    a_one_writer: assert property (
        @(posedge CLK) disable iff (rst)
        !(load_q.valid && pass_q.valid)
    ) else $error("load and passthrough write in the same cycle");

endmodule

// File: rtl/mem_stage_top.sv
`timescale 1ns/10ps

module mem_stage_top import mem_stage_pkg::*; (
    input  logic      CLK,
    input  logic      rst,
    input  exec_req_t req,
    output reg_wr_t   retire,
    output logic      fault
);

    reg_wr_t  pass_w;
    mem_rd_t  load_r;
    mem_wr_t  store_w;
    ram_idx_t rd_idx;
    word_t    rdata;
    reg_wr_t  pass_q;
    reg_wr_t  load_q;
    mem_wr_t  store_q;
    mem_wr_t  ram_wr;

    mem_cushion u_cushion (
        .CLK     (CLK),
        .rst     (rst),
        .req     (req),
        .pass_w  (pass_w),
        .load_r  (load_r),
        .store_w (store_w),
        .rd_idx  (rd_idx),
        .fault   (fault)
    );

    data_ram u_ram (
        .CLK     (CLK),
        .rd_idx  (rd_idx),
        .rdata   (rdata),
        .wr      (ram_wr)
    );

    mem_read u_read (
        .CLK     (CLK),
        .rst     (rst),
        .pass_w  (pass_w),
        .load_r  (load_r),
        .store_w (store_w),
        .rdata   (rdata),
        .pass_q  (pass_q),
        .load_q  (load_q),
        .store_q (store_q)
    );

    mem_write u_write (
        .CLK     (CLK),
        .rst     (rst),
        .pass_q  (pass_q),
        .load_q  (load_q),
        .store_q (store_q),
        .ram_wr  (ram_wr),
        .retire  (retire)
    );

endmodule

// File: verification/mem_stage_tb.sv
`timescale 1ns/10ps

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int WAIT_LIMIT   = 10;
    localparam int QUIET_CYCLES = 4;

    logic       CLK;
    logic       rst;
    exec_req_t  req;
    reg_wr_t    retire;
    logic       fault;
    logic [7:0] ref_mem [RAM_DEPTH*4];           // Byte addressed
    logic [31:0] lfsr;
    int         errors;
    int         checks;

    mem_stage_top uut (.CLK(CLK), .rst(rst), .req(req), .retire(retire), .fault(fault));

    always #20 CLK = ~CLK;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return b;
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[XLEN-2:0], lfsr_bit()};
        end
        return r;
    endfunction

    function automatic int size_bytes(input acc_size_t size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // Little-endian bytes, low bytes of data first
    function automatic void model_store(input word_t addr, input acc_size_t size, input word_t data);
        for (int i = 0; i < size_bytes(size); i++) begin
            ref_mem[10'(addr + 32'(i))] = data[8*i +: 8];
        end
    endfunction

    function automatic word_t model_load(input word_t addr, input acc_size_t size, input logic sext);
        word_t v;
        int    n;
        n = size_bytes(size);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[8*i +: 8] = ref_mem[10'(addr + 32'(i))];
        end
        if (sext && n < 4 && v[8*n-1]) begin
            for (int i = n; i < 4; i++) begin
                v[8*i +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    function automatic exec_req_t idle_req();
        exec_req_t r;
        r = '0;
        return r;
    endfunction

    function automatic exec_req_t alu_req(input reg_idx_t rd, input word_t data);
        exec_req_t r;
        r = idle_req();
        r.valid    = 1'b1;
        r.rd       = rd;
        r.alu_data = data;
        return r;
    endfunction

    function automatic exec_req_t load_req(input reg_idx_t rd, input word_t addr,
                                           input acc_size_t size, input logic sext);
        exec_req_t r;
        r = alu_req(rd, '0);
        r.load = 1'b1;
        r.addr = addr;
        r.size = size;
        r.sext = sext;
        return r;
    endfunction

    function automatic exec_req_t store_req(input word_t addr, input acc_size_t size,
                                            input word_t data);
        exec_req_t r;
        r = alu_req('0, '0);
        r.store      = 1'b1;
        r.addr       = addr;
        r.size       = size;
        r.store_data = data;
        return r;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_req(input exec_req_t r);
        @(posedge CLK);
        req <= r;
    endtask

    // Counts cycles from the last request until retire shows up
    task automatic await_retire(input string name, input reg_idx_t rd, input word_t data);
        int cnt;
        cnt = 0;
        while (cnt < WAIT_LIMIT) begin
            @(posedge CLK);
            req <= idle_req();
            @(negedge CLK);
            cnt++;
            if (retire.valid) begin
                break;
            end
        end
        if (!retire.valid) begin
            $display("Timeout: %s saw no retire within %0d cycles", name, WAIT_LIMIT);
            errors++;
        end else begin
            check_word({name, " latency"}, 32'd3, 32'(cnt));
            check_word({name, " rd"}, 32'(rd), 32'(retire.rd));
            check_word({name, " data"}, data, retire.data);
        end
    endtask

    // Fault is expected only in the cycle after the request
    task automatic expect_no_retire(input string name, input logic exp_fault);
        for (int c = 1; c <= QUIET_CYCLES; c++) begin
            @(posedge CLK);
            req <= idle_req();
            @(negedge CLK);
            check_word({name, " fault"}, 32'(c == 1 ? exp_fault : 1'b0), 32'(fault));
            check_word({name, " retire valid"}, '0, 32'(retire.valid));
        end
    endtask

    task automatic store_and_settle(input string name, input word_t addr,
                                    input acc_size_t size, input word_t data);
        send_req(store_req(addr, size, data));
        model_store(addr, size, data);
        expect_no_retire(name, 1'b0);
    endtask

    task automatic load_and_check(input string name, input reg_idx_t rd, input word_t addr,
                                  input acc_size_t size, input logic sext);
        send_req(load_req(rd, addr, size, sext));
        await_retire(name, rd, model_load(addr, size, sext));
    endtask

    task automatic word_roundtrip();
        word_t addr;
        for (int k = 0; k < 4; k++) begin
            addr = rand_bits(8) << 2;
            store_and_settle("word store", addr, SIZE_WORD, rand_bits(32));
            load_and_check("word load", 5'(rand_bits(5)) | 5'd1, addr, SIZE_WORD, 1'b0);
        end
    endtask

    task automatic sub_word_access();
        word_t base;
        word_t data;
        base = rand_bits(8) << 2;
        store_and_settle("init store", base, SIZE_WORD, rand_bits(32));
        for (int off = 0; off < 4; off++) begin
            data = (rand_bits(32) & ~32'h80) | (off % 2 == 1 ? 32'h80 : 32'h0);  // Both signs
            store_and_settle("byte store", base + 32'(off), SIZE_BYTE, data);
        end
        for (int off = 0; off < 4; off++) begin
            for (int s = 0; s < 2; s++) begin
                load_and_check($sformatf("byte load off %0d sext %0d", off, s),
                               5'd3, base + 32'(off), SIZE_BYTE, 1'(s));
            end
        end
        for (int off = 0; off < 4; off += 2) begin
            data = (rand_bits(32) & ~32'h8000) | (off == 2 ? 32'h8000 : 32'h0);
            store_and_settle("half store", base + 32'(off), SIZE_HALF, data);
            for (int s = 0; s < 2; s++) begin
                load_and_check($sformatf("half load off %0d sext %0d", off, s),
                               5'd12, base + 32'(off), SIZE_HALF, 1'(s));
            end
        end
        load_and_check("word after sub-word stores", 5'd31, base, SIZE_WORD, 1'b0);
    endtask

    // Load one cycle behind a store to the same word
    task automatic store_then_load_bypass();
        word_t base;
        word_t data;
        base = rand_bits(8) << 2;
        store_and_settle("bypass init", base, SIZE_WORD, rand_bits(32));
        data = rand_bits(32);
        send_req(store_req(base + 32'd1, SIZE_BYTE, data));
        model_store(base + 32'd1, SIZE_BYTE, data);
        load_and_check("bypass byte", 5'd5, base, SIZE_WORD, 1'b0);
        data = rand_bits(32);
        send_req(store_req(base + 32'd2, SIZE_HALF, data));
        model_store(base + 32'd2, SIZE_HALF, data);
        load_and_check("bypass half", 5'd6, base, SIZE_WORD, 1'b0);
    endtask

    task automatic misaligned_drop();
        word_t base;
        base = rand_bits(8) << 2;
        store_and_settle("misaligned init", base, SIZE_WORD, rand_bits(32));
        send_req(store_req(base + 32'd1, SIZE_HALF, rand_bits(32)));
        expect_no_retire("misaligned half store", 1'b1);
        send_req(store_req(base + 32'd2, SIZE_WORD, rand_bits(32)));
        expect_no_retire("misaligned word store", 1'b1);
        send_req(load_req(5'd9, base + 32'd3, SIZE_HALF, 1'b1));
        expect_no_retire("misaligned half load", 1'b1);
        send_req(load_req(5'd9, base + 32'd1, SIZE_WORD, 1'b0));
        expect_no_retire("misaligned word load", 1'b1);
        load_and_check("memory after misaligned", 5'd10, base, SIZE_WORD, 1'b0);
    endtask

    task automatic alu_passthrough();
        word_t    data;
        reg_idx_t rd;
        for (int k = 0; k < 4; k++) begin
            data = rand_bits(32);
            rd   = 5'(rand_bits(5)) | 5'd1;
            send_req(alu_req(rd, data));
            await_retire("alu result", rd, data);
        end
        send_req(alu_req(5'd0, rand_bits(32)));
        expect_no_retire("alu result to x0", 1'b0);
        send_req(load_req(5'd0, rand_bits(8) << 2, SIZE_WORD, 1'b0));
        expect_no_retire("load to x0", 1'b0);
    endtask

    initial begin
        CLK    = 1'b0;
        rst    = 1'b1;
        req    = idle_req();
        lfsr   = 32'hf91961e2;
        errors = 0;
        checks = 0;
        repeat (16) @(posedge CLK);
        rst <= 1'b0;

        expect_no_retire("idle after reset", 1'b0);
        word_roundtrip();
        sub_word_access();
        store_then_load_bypass();
        misaligned_drop();
        alu_passthrough();

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: mem_stage.f
rtl/mem_stage_pkg.sv
rtl/mem_cushion.sv
rtl/data_ram.sv
rtl/mem_read.sv
rtl/mem_write.sv
rtl/mem_stage_top.sv
verification/mem_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mem_stage_tb
FILELIST  := mem_stage.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Result: FAILED
PASS_MSG  := Result: PASSED
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
